// ==== jtag_tap_top.f ====
rtl/jtag_tap_pkg.sv
rtl/jtag_ir_pkg.sv
rtl/jtag_tap_fsm.sv
rtl/jtag_ir.sv
rtl/jtag_user_dr.sv
rtl/jtag_tdo_path.sv
rtl/jtag_tap_top.sv
tb/jtag_tap_chk.sv
tb/jtag_tap_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the JTAG TAP testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module jtag_tap_tb -f jtag_tap_top.f || exit 1
# A raised error limit lets the run reach its own closing report.
out="$(./obj_dir/Vjtag_tap_tb +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// ==== tb/jtag_tap_tb.sv ====
module jtag_tap_tb
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
();

    localparam int NUM_ROWS = 14;

    // One scan of the table with the values expected back from it.
    typedef struct packed {
        logic        is_ir;
        logic        pause;
        logic [5:0]  len;
        logic [31:0] tdi_word;
        logic [31:0] din;
        logic [31:0] exp_out;
        logic [31:0] exp_dout;
    } scan_row_t;

    logic                                      tck;
    logic                                      rst_n;
    logic                                      tms;
    logic                                      tdi;
    logic [NUM_USER_DR-1:0][USER_DR_WIDTH-1:0] user_din;
    logic [NUM_USER_DR-1:0][USER_DR_WIDTH-1:0] user_dout;
    logic                                      tdo;
    logic                                      tdo_en;

    scan_row_t   rows [NUM_ROWS];
    int          errors;
    int          chk_fails;
    integer      seed;
    logic [31:0] scan_out;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] wr;
    logic [31:0] byp;
    logic [31:0] dout_a;
    logic [31:0] dout_b;
    logic [31:0] dout_c;

    jtag_tap_top u_jtag_tap_top (
        .tck       (tck),
        .rst_n     (rst_n),
        .tms       (tms),
        .tdi       (tdi),
        .user_din  (user_din),
        .user_dout (user_dout),
        .tdo       (tdo),
        .tdo_en    (tdo_en)
    );

    always #20 tck = ~tck;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Inputs change 5 units after each rising edge.
    task automatic next_cycle();
        @(posedge tck);
        #5;
    endtask

    task automatic tms_step(input logic t);
        tms = t;
        tdi = 1'b0;
        next_cycle();
    endtask

    // Returns 5 units after the falling edge on which tdo_en first shows a Shift state.
    task automatic wait_shift(input string what);
        int n;
        for (n = 0; n < 6; n++) begin
            @(negedge tck);
            #5;
            if (tdo_en) break;
            next_cycle();
        end
        if (n == 6) begin
            $display("Timeout: tdo_en never rose during the %s scan", what);
            errors++;
        end
    endtask

    // Walks Run-Test-Idle through one IR or DR scan and back to Run-Test-Idle.
    // With pause set, the scan leaves Shift halfway for three cycles in Pause.
    task automatic scan(input logic is_ir, input int len, input logic [31:0] data,
                        input logic pause, output logic [31:0] captured);
        int half;
        int i;
        half = len / 2;
        captured = '0;
        tms_step(1'b1);
        if (is_ir) tms_step(1'b1);
        tms_step(1'b0);
        for (i = 0; i < len; i++) begin
            tms = (i == len - 1) || (pause && i == half - 1);
            tdi = data[i];
            // Entry into Shift comes from Capture or from Exit2.
            if (i == 0 || (pause && i == half)) begin
                wait_shift(is_ir ? "IR" : "DR");
            end else begin
                @(negedge tck);
                #5;
                check("tdo_en", 32'(tdo_en), 32'd1);
            end
            captured[i] = tdo;
            next_cycle();
            if (pause && i == half - 1) begin
                tms_step(1'b0);
                tms_step(1'b0);
                tms_step(1'b0);
                tms_step(1'b1);
            end
        end
        // Exit1 to Update, then Run-Test-Idle.
        tms_step(1'b1);
        tms_step(1'b0);
    endtask

    task automatic set_row(input int idx, input logic is_ir, input logic pause, input int len,
                           input logic [31:0] data, input logic [31:0] din,
                           input logic [31:0] exp_out, input logic [31:0] exp_dout);
        rows[idx] = '{is_ir, pause, 6'(len), data, din, exp_out, exp_dout};
    endtask

    task automatic apply_row(input int idx);
        scan_row_t   r;
        logic [31:0] mask;
        r = rows[idx];
        mask = (r.len >= 6'd32) ? 32'hFFFF_FFFF : ((32'd1 << r.len) - 32'd1);
        user_din = r.din;
        scan(r.is_ir, int'(r.len), r.tdi_word, r.pause, scan_out);
        check($sformatf("tdo word row %0d", idx), scan_out & mask, r.exp_out & mask);
        check($sformatf("user_dout row %0d", idx), user_dout, r.exp_dout);
    endtask

    initial begin
        tck = 1'b0;
        rst_n = 1'b0;
        tms = 1'b1;
        tdi = 1'b0;
        user_din = '0;
        errors = 0;
        seed = 32'h491b3fe4;
        d0 = $random(seed);
        d1 = $random(seed);
        wr = $random(seed);
        byp = $random(seed);
        // Expected user_dout after the USER2, USER0 and USER3 writes.
        dout_a = {8'h00, wr[15:8], 16'h0000};
        dout_b = {8'h00, wr[15:8], 8'h00, wr[7:0]};
        dout_c = {wr[23:16], wr[15:8], 8'h00, wr[7:0]};
        set_row(0, 1'b0, 1'b0, 32, byp, d0, IDCODE_VALUE, 32'h0);
        set_row(1, 1'b1, 1'b0, 4, 32'(IR_USER2), d0, 32'(IR_CAPTURE), 32'h0);
        // The unpaused USER2 scan writes the inverted byte, so the paused scan must update.
        set_row(2, 1'b0, 1'b0, 8, {24'h0, ~wr[15:8]}, d0, {24'h0, d0[23:16]},
                {8'h00, ~wr[15:8], 16'h0000});
        set_row(3, 1'b0, 1'b1, 8, {24'h0, wr[15:8]}, d0, {24'h0, d0[23:16]}, dout_a);
        set_row(4, 1'b1, 1'b0, 4, 32'(IR_USER0), d0, 32'(IR_CAPTURE), dout_a);
        set_row(5, 1'b0, 1'b0, 8, {24'h0, wr[7:0]}, d1, {24'h0, d1[7:0]}, dout_b);
        set_row(6, 1'b1, 1'b0, 4, 32'(IR_BYPASS), d1, 32'(IR_CAPTURE), dout_b);
        // A bypassed scan returns a leading zero, then tdi one bit late.
        set_row(7, 1'b0, 1'b0, 12, byp, d1, byp << 1, dout_b);
        set_row(8, 1'b1, 1'b0, 4, 32'h3, d1, 32'(IR_CAPTURE), dout_b);
        set_row(9, 1'b0, 1'b1, 16, byp, d1, byp << 1, dout_b);
        set_row(10, 1'b1, 1'b0, 4, 32'(IR_IDCODE), d1, 32'(IR_CAPTURE), dout_b);
        set_row(11, 1'b0, 1'b0, 32, byp, d1, IDCODE_VALUE, dout_b);
        set_row(12, 1'b1, 1'b0, 4, 32'(IR_USER3), d0, 32'(IR_CAPTURE), dout_b);
        set_row(13, 1'b0, 1'b0, 8, {24'h0, wr[23:16]}, d0, {24'h0, d0[31:24]}, dout_c);

        repeat (8) @(posedge tck);
        #5;
        rst_n = 1'b1;
        @(negedge tck);
        #5;
        check("tdo", 32'(tdo), 32'd0);
        check("tdo_en", 32'(tdo_en), 32'd0);
        next_cycle();
        tms_step(1'b0);
        for (int idx = 0; idx < NUM_ROWS; idx++) begin
            apply_row(idx);
        end

        // Break off a USER3 scan in Capture-DR with five tms highs.
        // The core value equals the held byte, so passing Update-DR rewrites it unchanged.
        user_din = {dout_c[31:24], d0[23:0]};
        tms_step(1'b1);
        tms_step(1'b0);
        repeat (5) tms_step(1'b1);
        check("state", 32'(u_jtag_tap_top.state), 32'(TAP_TEST_LOGIC_RESET));
        tms_step(1'b0);
        scan(1'b0, 32, byp, 1'b0, scan_out);
        check("tdo word after reset", scan_out, IDCODE_VALUE);
        check("user_dout after reset", user_dout, dout_c);

        chk_fails = u_jtag_tap_top.u_chk.fail_count;
        $display("Errors: %0d in checks, %0d in assertions", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/jtag_tap_chk.sv ====
module jtag_tap_chk
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
(
    input logic                                      tck,
    input logic                                      rst_n,
    input logic                                      tms,
    input tap_state_e                                state,
    input logic                                      tdo_en,
    input logic [NUM_USER_DR-1:0][USER_DR_WIDTH-1:0] user_dout
);

    int   fail_count = 0;
    logic in_shift;

    assign in_shift = (state == TAP_SHIFT_DR) || (state == TAP_SHIFT_IR);

    // tdo_en is loaded on the falling edge from the state of that cycle.
    // At the next rising edge the state register still holds that state.
    a_tdo_en: assert property (@(posedge tck) disable iff (!rst_n) tdo_en == in_shift)
        else begin
            $error("tdo_en does not follow the Shift states");
            fail_count++;
        end

    // Five tms highs in a row reach Test-Logic-Reset from any state.
    a_five_tms: assert property (@(posedge tck) disable iff (!rst_n)
        (tms && $past(tms, 1) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4))
        |=> (state == TAP_TEST_LOGIC_RESET))
        else begin
            $error("five tms highs did not reach Test-Logic-Reset");
            fail_count++;
        end

    // A change on user_dout must come from the edge that left Update-DR.
    a_dout_update: assert property (@(posedge tck) disable iff (!rst_n)
        (user_dout != $past(user_dout)) |-> ($past(state) == TAP_UPDATE_DR))
        else begin
            $error("user_dout changed outside Update-DR");
            fail_count++;
        end

endmodule

bind jtag_tap_top jtag_tap_chk u_chk (
    .tck       (tck),
    .rst_n     (rst_n),
    .tms       (tms),
    .state     (state),
    .tdo_en    (tdo_en),
    .user_dout (user_dout)
);

// ==== rtl/jtag_tap_top.sv ====
module jtag_tap_top
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
(
    input  logic                                        tck,
    input  logic                                        rst_n,
    input  logic                                        tms,
    input  logic                                        tdi,
    input  logic [NUM_USER_DR-1:0][USER_DR_WIDTH-1:0]   user_din,
    output logic [NUM_USER_DR-1:0][USER_DR_WIDTH-1:0]   user_dout,
    output logic                                        tdo,
    output logic                                        tdo_en
);

    tap_state_e             state;
    tap_ctrl_t              ctrl;
    dr_sel_t                sel;
    logic                   ir_so;
    logic [NUM_USER_DR-1:0] user_so;

    // TAP controller.
    // The state is also brought out here for the bound checker.
    jtag_tap_fsm u_fsm (
        .tck   (tck),
        .rst_n (rst_n),
        .tms   (tms),
        .state (state),
        .ctrl  (ctrl)
    );

    // Instruction register and its decode into a data register select.
    jtag_ir u_ir (
        .tck   (tck),
        .rst_n (rst_n),
        .tdi   (tdi),
        .ctrl  (ctrl),
        .ir_so (ir_so),
        .sel   (sel)
    );

    // One user data register per select bit.
    for (genvar k = 0; k < NUM_USER_DR; k++) begin : g_user_dr
        jtag_user_dr u_user_dr (
            .tck      (tck),
            .rst_n    (rst_n),
            .tdi      (tdi),
            .ctrl     (ctrl),
            .selected (sel.user[k]),
            .din      (user_din[k]),
            .dout     (user_dout[k]),
            .so       (user_so[k])
        );
    end

    // BYPASS, IDCODE and the falling-edge output stage.
    jtag_tdo_path u_tdo (
        .tck     (tck),
        .rst_n   (rst_n),
        .tdi     (tdi),
        .ctrl    (ctrl),
        .sel     (sel),
        .ir_so   (ir_so),
        .user_so (user_so),
        .tdo     (tdo),
        .tdo_en  (tdo_en)
    );

endmodule

// ==== rtl/jtag_tdo_path.sv ====
module jtag_tdo_path
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
(
    input  logic                   tck,
    input  logic                   rst_n,
    input  logic                   tdi,
    input  tap_ctrl_t              ctrl,
    input  dr_sel_t                sel,
    input  logic                   ir_so,
    input  logic [NUM_USER_DR-1:0] user_so,
    output logic                   tdo,
    output logic                   tdo_en
);

    logic                    bypass_reg;
    logic [IDCODE_WIDTH-1:0] idcode_shift;
    logic                    dr_so;
    logic                    shifting;

    // BYPASS register.
    // It captures 0, so a bypassed scan returns one leading zero.
    always_ff @(posedge tck) begin
        if (sel.bypass && ctrl.capture_dr) begin
            bypass_reg <= 1'b0;
        end else if (sel.bypass && ctrl.shift_dr) begin
            bypass_reg <= tdi;
        end
    end

    // IDCODE register.
    // It captures the device word and shifts it out low bit first.
    always_ff @(posedge tck) begin
        if (sel.idcode && ctrl.capture_dr) begin
            idcode_shift <= IDCODE_VALUE;
        end else if (sel.idcode && ctrl.shift_dr) begin
            idcode_shift <= {tdi, idcode_shift[IDCODE_WIDTH-1:1]};
        end
    end

    // Serial bit of the selected data register.
    // The select is one-hot, so the terms can be ORed together.
    assign dr_so = (sel.bypass & bypass_reg) | (sel.idcode & idcode_shift[0])
                 | (|(sel.user & user_so));

    assign shifting = ctrl.shift_dr | ctrl.shift_ir;

    // Output register on the falling edge, half a cycle after the shift edge.
    // Outside the Shift states tdo is parked at 0 and tdo_en drops.
    always_ff @(negedge tck or negedge rst_n) begin
        if (!rst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo_en <= shifting;
            tdo    <= shifting ? (ctrl.shift_ir ? ir_so : dr_so) : 1'b0;
        end
    end

endmodule

// ==== rtl/jtag_user_dr.sv ====
module jtag_user_dr
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
(
    input  logic                     tck,
    input  logic                     rst_n,
    input  logic                     tdi,
    input  tap_ctrl_t                ctrl,
    input  logic                     selected,
    input  logic [USER_DR_WIDTH-1:0] din,
    output logic [USER_DR_WIDTH-1:0] dout,
    output logic                     so
);

    logic [USER_DR_WIDTH-1:0] dr_shift;

    // Shift stage.
    // It only moves while the current instruction selects this register.
    // Capture-DR samples the core value, Shift-DR moves tdi in at the top.
    always_ff @(posedge tck) begin
        if (selected && ctrl.capture_dr) begin
            dr_shift <= din;
        end else if (selected && ctrl.shift_dr) begin
            dr_shift <= {tdi, dr_shift[USER_DR_WIDTH-1:1]};
        end
    end

    // Serial output toward the TDO multiplexer.
    assign so = dr_shift[0];

    // Parallel output to the core.
    // It changes only on the edge that leaves Update-DR.
    // While another register is selected, the value is kept.
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (selected && ctrl.update_dr) begin
            dout <= dr_shift;
        end
    end

    // Test-Logic-Reset leaves dout alone.
    // The core keeps its settings across a TAP reset.

endmodule

// ==== rtl/jtag_ir.sv ====
module jtag_ir
    import jtag_tap_pkg::*;
    import jtag_ir_pkg::*;
(
    input  logic      tck,
    input  logic      rst_n,
    input  logic      tdi,
    input  tap_ctrl_t ctrl,
    output logic      ir_so,
    output dr_sel_t   sel
);

    logic [IR_WIDTH-1:0] ir_shift;
    ir_opcode_e          ir_op;

    // Shift stage of the instruction register.
    // Capture-IR loads the fixed pattern, Shift-IR moves tdi in at the top.
    // In every other state the stage holds its contents.
    always_ff @(posedge tck) begin
        if (ctrl.capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (ctrl.shift_ir) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    // The low bit leaves the chain first.
    assign ir_so = ir_shift[0];

    // Update latch that holds the current instruction.
    // Test-Logic-Reset restores IDCODE one edge after it is entered.
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            ir_op <= IR_IDCODE;
        end else if (ctrl.test_logic_reset) begin
            ir_op <= IR_IDCODE;
        end else if (ctrl.update_ir) begin
            ir_op <= ir_opcode_e'(ir_shift);
        end
    end

    // Decode of the current instruction into a data register select.
    // The two low opcode bits pick the user register.
    always_comb begin
        sel = '0;
        case (ir_op)
            IR_IDCODE: sel.idcode = 1'b1;
            IR_USER0, IR_USER1, IR_USER2, IR_USER3: begin
                sel.user[ir_op[1:0]] = 1'b1;
            end
            // BYPASS and every unlisted code land here.
            default: sel.bypass = 1'b1;
        endcase
    end

endmodule

// ==== rtl/jtag_tap_fsm.sv ====
module jtag_tap_fsm
    import jtag_tap_pkg::*;
(
    input  logic       tck,
    input  logic       rst_n,
    input  logic       tms,
    output tap_state_e state,
    output tap_ctrl_t  ctrl
);

    tap_state_e next_state;

    // The state moves on every rising tck edge.
    // Reset forces Test-Logic-Reset at once, without waiting for tck.
    always_ff @(posedge tck or negedge rst_n) begin
        if (!rst_n) begin
            state <= TAP_TEST_LOGIC_RESET;
        end else begin
            state <= next_state;
        end
    end

    // Next-state logic of the standard sixteen-state graph.
    // Five tms highs reach Test-Logic-Reset from any state through these arcs.
    always_comb begin
        case (state)
            TAP_TEST_LOGIC_RESET: next_state = tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    next_state = tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR_SCAN:   next_state = tms ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       next_state = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         next_state = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         next_state = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         next_state = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         next_state = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        next_state = tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR_SCAN:   next_state = tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       next_state = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         next_state = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         next_state = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         next_state = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         next_state = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        next_state = tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            // An encoding outside the graph falls back to reset.
            default:              next_state = TAP_TEST_LOGIC_RESET;
        endcase
    end

    // Strobes decoded from the current state.
    // They are plain levels that stay high for the whole state.
    // The registers act on the rising edge that leaves the state.
    always_comb begin
        ctrl.test_logic_reset = (state == TAP_TEST_LOGIC_RESET);
        ctrl.capture_dr       = (state == TAP_CAPTURE_DR);
        ctrl.shift_dr         = (state == TAP_SHIFT_DR);
        ctrl.update_dr        = (state == TAP_UPDATE_DR);
        ctrl.capture_ir       = (state == TAP_CAPTURE_IR);
        ctrl.shift_ir         = (state == TAP_SHIFT_IR);
        ctrl.update_ir        = (state == TAP_UPDATE_IR);
    end

    // The pause, exit and select states have no strobe of their own.
    // In them every shift stage simply holds its contents.

endmodule

// ==== rtl/jtag_ir_pkg.sv ====
package jtag_ir_pkg;

    // Width of the instruction register.
    localparam int IR_WIDTH = 4;

    // Pattern loaded in Capture-IR.
    // The two low bits must read 01 for chain integrity checks.
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0101;

    // Instruction opcodes.
    // Any value not listed here behaves as BYPASS.
    typedef enum logic [IR_WIDTH-1:0] {
        IR_IDCODE = 4'h1,
        IR_USER0  = 4'h8,
        IR_USER1  = 4'h9,
        IR_USER2  = 4'hA,
        IR_USER3  = 4'hB,
        IR_BYPASS = 4'hF
    } ir_opcode_e;

    // Number and width of the user data registers.
    localparam int NUM_USER_DR   = 4;
    localparam int USER_DR_WIDTH = 8;

    // Device identification word; bit 0 is fixed to 1 by the standard.
    localparam int                      IDCODE_WIDTH = 32;
    localparam logic [IDCODE_WIDTH-1:0] IDCODE_VALUE = 32'h1B3F_E001;

    // Data register select decoded from the current instruction.
    // Exactly one of the three fields is active at any time.
    typedef struct packed {
        logic [NUM_USER_DR-1:0] user;
        logic                   idcode;
        logic                   bypass;
    } dr_sel_t;

endpackage

// ==== rtl/jtag_tap_pkg.sv ====
package jtag_tap_pkg;

    // The TAP controller state is held in four bits.
    localparam int TAP_STATE_WIDTH = 4;

    // The sixteen states of the TAP controller.
    // The encodings follow the usual JTAG controller numbering.
    // Test-Logic-Reset is all ones, so a stuck-high register lands there.
    typedef enum logic [TAP_STATE_WIDTH-1:0] {
        TAP_EXIT2_DR         = 4'h0,
        TAP_EXIT1_DR         = 4'h1,
        TAP_SHIFT_DR         = 4'h2,
        TAP_PAUSE_DR         = 4'h3,
        TAP_SELECT_IR_SCAN   = 4'h4,
        TAP_UPDATE_DR        = 4'h5,
        TAP_CAPTURE_DR       = 4'h6,
        TAP_SELECT_DR_SCAN   = 4'h7,
        TAP_EXIT2_IR         = 4'h8,
        TAP_EXIT1_IR         = 4'h9,
        TAP_SHIFT_IR         = 4'hA,
        TAP_PAUSE_IR         = 4'hB,
        TAP_RUN_TEST_IDLE    = 4'hC,
        TAP_UPDATE_IR        = 4'hD,
        TAP_CAPTURE_IR       = 4'hE,
        TAP_TEST_LOGIC_RESET = 4'hF
    } tap_state_e;

    // Decoded state strobes sent from the controller to every register.
    // Each strobe is high for the whole cycle spent in its state.
    typedef struct packed {
        logic test_logic_reset;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
    } tap_ctrl_t;

endpackage
